// ==== verilog/memory_game_pkg.sv ====
package memory_game_pkg;

    // Number of words in the sequence ROM
    localparam int SEQ_DEPTH = 16;

    // Switch bank and pattern width
    localparam int PLAY_WIDTH = 4;

    // Controller states
    typedef enum logic [3:0] {
        st_idle,
        st_setup,
        st_wait_play,
        st_register_play,
        st_compare_play,
        st_next_round,
        st_won,
        st_lost,
        st_timed_out
    } game_state_t;

    // Fixed game sequence, one switch per round
    localparam logic [PLAY_WIDTH-1:0] seq_rom_contents [SEQ_DEPTH] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

endpackage

// ==== verilog/play_capture.sv ====
module play_capture (
    input  logic                                  clock,
    input  logic                                  arst_n,
    // Raw switch bank
    input  logic [memory_game_pkg::PLAY_WIDTH-1:0] switches,
    // Strobes from the controller
    input  logic                                  load_play,
    input  logic                                  clear_play,
    // Press detected
    output logic                                  play_made,
    // Last registered pattern
    output logic [memory_game_pkg::PLAY_WIDTH-1:0] play
);

    // Any switch up
    logic any_on;
    // Delayed copies of any_on for edge detection
    logic any_on_q;
    logic any_on_qq;

    assign any_on = |switches;

    // Two stage history of the OR of the switches
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            any_on_q  <= 1'b0;
            any_on_qq <= 1'b0;
        end else begin
            any_on_q  <= any_on;
            any_on_qq <= any_on_q;
        end
    end

    // Rising edge of the registered OR
    // One cycle wide, one cycle after the switches leave zero
    assign play_made = any_on_q & ~any_on_qq;

    // Play register
    // Clear wins over load
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            play <= '0;
        end else if (clear_play) begin
            play <= '0;
        end else if (load_play) begin
            play <= switches;
        end
    end

endmodule

// ==== verilog/sequence_memory.sv ====
module sequence_memory (
    input  logic                                           clock,
    input  logic                                           arst_n,
    // Round counter controls
    input  logic                                           clear_round,
    input  logic                                           next_round,
    // Registered play to compare
    input  logic [memory_game_pkg::PLAY_WIDTH-1:0]         play,
    // Play equals expected word
    output logic                                           match,
    // Final round of each level
    output logic                                           last_round8,
    output logic                                           last_round16,
    // Current round, also shown on the board
    output logic [$clog2(memory_game_pkg::SEQ_DEPTH)-1:0] round
);

    import memory_game_pkg::*;

    localparam int ROUND_WIDTH = $clog2(SEQ_DEPTH);

    // Counter value of the last round at each level
    localparam logic [ROUND_WIDTH-1:0] LAST8  = ROUND_WIDTH'(7);
    localparam logic [ROUND_WIDTH-1:0] LAST16 = ROUND_WIDTH'(SEQ_DEPTH - 1);

    logic [ROUND_WIDTH-1:0] round_q;
    // Registered ROM output
    logic [PLAY_WIDTH-1:0]  rom_data;

    // Round counter
    // Synchronous clear has priority over the increment
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round_q <= '0;
        end else if (clear_round) begin
            round_q <= '0;
        end else if (next_round) begin
            round_q <= round_q + 1'b1;
        end
    end

    // Synchronous ROM
    // Word is valid the cycle after the address moves
    always_ff @(posedge clock) begin
        rom_data <= seq_rom_contents[round_q];
    end

    // Comparison on the registered word
    assign match = (rom_data == play);

    // End of game decode
    assign last_round8  = (round_q == LAST8);
    assign last_round16 = (round_q == LAST16);

    assign round = round_q;

endmodule

// ==== verilog/play_timer.sv ====
module play_timer #(
    // Waiting cycles allowed before a timeout
    parameter int TIMEOUT_CYCLES = 3000
) (
    input  logic clock,
    input  logic arst_n,
    // High while waiting for a press
    input  logic count_wait,
    // Press seen, restart the count
    input  logic play_made,
    // Wait limit reached
    output logic timeout
);

    localparam int CNT_WIDTH = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_WIDTH-1:0] LIMIT = CNT_WIDTH'(TIMEOUT_CYCLES);

    logic [CNT_WIDTH-1:0] wait_cnt;

    // Wait counter
    // Cleared outside the waiting state and on every press
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (!count_wait || play_made) begin
            wait_cnt <= '0;
        end else if (wait_cnt != LIMIT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Saturated count means timeout
    assign timeout = (wait_cnt == LIMIT);

endmodule

// ==== verilog/game_control.sv ====
module game_control (
    input  logic clock,
    input  logic arst_n,
    // Player controls
    input  logic start,
    input  logic level,
    // Status from the datapath
    input  logic play_made,
    input  logic match,
    input  logic last_round8,
    input  logic last_round16,
    input  logic timeout,
    // Datapath strobes
    output logic load_play,
    output logic clear_play,
    output logic clear_round,
    output logic next_round,
    output logic count_wait,
    // Game status
    output logic ready,
    output logic game_won,
    output logic game_lost,
    output logic game_timeout
);

    import memory_game_pkg::*;

    game_state_t state_q;
    game_state_t state_d;

    // Level latched at the start of a game
    logic level_q;
    // Final round for the latched level
    logic last_round;

    // State register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Level register, loaded in setup only
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            level_q <= 1'b0;
        end else if (state_q == st_setup) begin
            level_q <= level;
        end
    end

    // 16 rounds when level is high, 8 otherwise
    assign last_round = level_q ? last_round16 : last_round8;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_setup;
                end
            end
            st_setup: begin
                state_d = st_wait_play;
            end
            // Press beats timeout when both arrive together
            st_wait_play: begin
                if (play_made) begin
                    state_d = st_register_play;
                end else if (timeout) begin
                    state_d = st_timed_out;
                end
            end
            st_register_play: begin
                state_d = st_compare_play;
            end
            st_compare_play: begin
                if (!match) begin
                    state_d = st_lost;
                end else if (last_round) begin
                    state_d = st_won;
                end else begin
                    state_d = st_next_round;
                end
            end
            st_next_round: begin
                state_d = st_wait_play;
            end
            // Outcome states hold until a new start
            st_won, st_lost, st_timed_out: begin
                if (start) begin
                    state_d = st_setup;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // Moore outputs
    assign clear_play   = (state_q == st_setup);
    assign clear_round  = (state_q == st_setup);
    assign count_wait   = (state_q == st_wait_play);
    assign load_play    = (state_q == st_register_play);
    assign next_round   = (state_q == st_next_round);
    assign game_won     = (state_q == st_won);
    assign game_lost    = (state_q == st_lost);
    assign game_timeout = (state_q == st_timed_out);

    // Ready when no game is running
    assign ready = (state_q == st_idle) | game_won | game_lost | game_timeout;

endmodule

// ==== verilog/memory_game_top.sv ====
module memory_game_top #(
    // Waiting cycles before a press times out
    parameter int TIMEOUT_CYCLES = 3000
) (
    input  logic                                           clock,
    input  logic                                           arst_n,
    // Game controls
    input  logic                                           start,
    input  logic                                           level,
    input  logic [memory_game_pkg::PLAY_WIDTH-1:0]         switches,
    // Game status
    output logic                                           ready,
    output logic                                           game_won,
    output logic                                           game_lost,
    output logic                                           game_timeout,
    // Display values
    output logic [memory_game_pkg::PLAY_WIDTH-1:0]         play,
    output logic [$clog2(memory_game_pkg::SEQ_DEPTH)-1:0] round
);

    // Capture to controller
    logic play_made;
    // Controller strobes
    logic load_play;
    logic clear_play;
    logic clear_round;
    logic next_round;
    logic count_wait;
    // Datapath status
    logic match;
    logic last_round8;
    logic last_round16;
    logic timeout;

    // Press detection and play register
    play_capture u_play_capture (
        .clock      (clock),
        .arst_n     (arst_n),
        .switches   (switches),
        .load_play  (load_play),
        .clear_play (clear_play),
        .play_made  (play_made),
        .play       (play)
    );

    // Round counter, ROM and compare
    sequence_memory u_sequence_memory (
        .clock        (clock),
        .arst_n       (arst_n),
        .clear_round  (clear_round),
        .next_round   (next_round),
        .play         (play),
        .match        (match),
        .last_round8  (last_round8),
        .last_round16 (last_round16),
        .round        (round)
    );

    // Press timeout
    play_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_play_timer (
        .clock      (clock),
        .arst_n     (arst_n),
        .count_wait (count_wait),
        .play_made  (play_made),
        .timeout    (timeout)
    );

    // Game FSM
    game_control u_game_control (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (start),
        .level        (level),
        .play_made    (play_made),
        .match        (match),
        .last_round8  (last_round8),
        .last_round16 (last_round16),
        .timeout      (timeout),
        .load_play    (load_play),
        .clear_play   (clear_play),
        .clear_round  (clear_round),
        .next_round   (next_round),
        .count_wait   (count_wait),
        .ready        (ready),
        .game_won     (game_won),
        .game_lost    (game_lost),
        .game_timeout (game_timeout)
    );

endmodule

// ==== tb/memory_game_checker.sv ====
module memory_game_checker (
    input logic clock,
    input logic arst_n,
    input logic start,
    input logic load_play,
    input logic game_won,
    input logic game_lost,
    input logic game_timeout
);

    // Outcomes are mutually exclusive
    assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0({game_won, game_lost, game_timeout}))
        else $error("more than one outcome level is high");

    // One load per press
    assert property (@(posedge clock) disable iff (!arst_n)
        load_play |=> !load_play)
        else $error("load_play high on two consecutive cycles");

    // Each outcome holds until the next start
    assert property (@(posedge clock) disable iff (!arst_n)
        (game_won && !start) |=> game_won)
        else $error("game_won dropped without start");
    assert property (@(posedge clock) disable iff (!arst_n)
        (game_lost && !start) |=> game_lost)
        else $error("game_lost dropped without start");
    assert property (@(posedge clock) disable iff (!arst_n)
        (game_timeout && !start) |=> game_timeout)
        else $error("game_timeout dropped without start");

endmodule

bind game_control memory_game_checker u_memory_game_checker (
    .clock        (clock),
    .arst_n       (arst_n),
    .start        (start),
    .load_play    (load_play),
    .game_won     (game_won),
    .game_lost    (game_lost),
    .game_timeout (game_timeout)
);

// ==== tb/memory_game_tb.sv ====
module memory_game_tb;

    import memory_game_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int ROUND_W = $clog2(SEQ_DEPTH);
    localparam int MAX_PLAYS = 16;
    localparam int MAX_GAP = 5;
    localparam int LONG_GAP = 60;
    localparam int READY_LIMIT = 100;
    // Press is 3 cycles on, 3 off, plus its gap; 64 presses is a safe upper bound
    localparam int WATCHDOG_CYCLES = 64 * (6 + MAX_GAP) + 2 * LONG_GAP + 400;
    localparam int OUT_NONE = 0;
    localparam int OUT_WON = 1;
    localparam int OUT_LOST = 2;
    localparam int OUT_TIMEOUT = 3;

    logic clock;
    logic arst_n;
    logic start;
    logic level;
    logic [PLAY_WIDTH-1:0] switches;
    logic ready;
    logic game_won;
    logic game_lost;
    logic game_timeout;
    logic [PLAY_WIDTH-1:0] play;
    logic [ROUND_W-1:0] round;

    // Patterns, gaps before each press and level of the current game
    logic [PLAY_WIDTH-1:0] pats [MAX_PLAYS];
    int gaps [MAX_PLAYS];
    int n_plays;
    logic game_level;
    // Expected results
    int exp_outcome;
    logic [ROUND_W-1:0] exp_round;
    logic [PLAY_WIDTH-1:0] exp_play;
    string test_name;
    int tests_run;
    int tests_failed;
    integer seed;
    // Set by the stimulus, cleared by the compare process when done
    logic check_req;

    memory_game_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_memory_game_top (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (start),
        .level        (level),
        .switches     (switches),
        .ready        (ready),
        .game_won     (game_won),
        .game_lost    (game_lost),
        .game_timeout (game_timeout),
        .play         (play),
        .round        (round)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Expected outcome of a game from the game rules
    function automatic int expected_result(
        input  logic                  lvl,
        input  logic [PLAY_WIDTH-1:0] plays [MAX_PLAYS],
        input  int                    waits [MAX_PLAYS],
        input  int                    count,
        output logic [ROUND_W-1:0]    res_round,
        output logic [PLAY_WIDTH-1:0] res_play
    );
        int k;
        int idle;
        int rounds;
        rounds = lvl ? 16 : 8;
        res_round = '0;
        res_play = '0;
        for (k = 0; k < count; k++) begin
            // Cycles in wait_play with no press seen; later rounds pass next_round first
            idle = waits[k] + ((k == 0) ? 1 : 2);
            res_round = ROUND_W'(k);
            if (idle > TIMEOUT_CYCLES) begin
                return OUT_TIMEOUT;
            end
            res_play = plays[k];
            if (plays[k] != seq_rom_contents[k]) begin
                return OUT_LOST;
            end
            if (k == rounds - 1) begin
                return OUT_WON;
            end
        end
        return OUT_NONE;
    endfunction

    function automatic int random_gap();
        return $unsigned($random(seed)) % (MAX_GAP + 1);
    endfunction

    // Random non-zero pattern other than the expected one
    function automatic logic [PLAY_WIDTH-1:0] wrong_pattern(input logic [PLAY_WIDTH-1:0] good);
        logic [PLAY_WIDTH-1:0] p;
        p = good;
        while (p == good || p == '0) begin
            p = PLAY_WIDTH'($random(seed));
        end
        return p;
    endfunction

    task automatic press(input logic [PLAY_WIDTH-1:0] pat, input int gap);
        repeat (gap) begin
            @(posedge clock);
            switches <= '0;
        end
        repeat (3) begin
            @(posedge clock);
            switches <= pat;
        end
        repeat (3) begin
            @(posedge clock);
            switches <= '0;
        end
    endtask

    // Wait for ready with a limit and let the compare process check
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!ready && waited < READY_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        test_name = name;
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic play_game(input string name);
        int k;
        exp_outcome = expected_result(game_level, pats, gaps, n_plays, exp_round, exp_play);
        @(posedge clock);
        start <= 1'b1;
        level <= game_level;
        @(posedge clock);
        start <= 1'b0;
        for (k = 0; k < n_plays; k++) begin
            press(pats[k], gaps[k]);
        end
        finish_test(name);
    endtask

    task automatic correct_game(input logic lvl, input string name);
        int k;
        game_level = lvl;
        n_plays = lvl ? 16 : 8;
        for (k = 0; k < n_plays; k++) begin
            pats[k] = seq_rom_contents[k];
            gaps[k] = random_gap();
        end
        play_game(name);
    endtask

    // Compare process sampling outputs at the falling edge
    initial begin
        int errs;
        tests_run = 0;
        tests_failed = 0;
        check_req = 1'b0;
        forever begin
            wait (check_req);
            errs = 0;
            if (ready !== 1'b1) begin
                $display("%0t: %s: ready did not return within %0d cycles",
                         $time, test_name, READY_LIMIT);
                errs++;
            end
            if (game_won !== (exp_outcome == OUT_WON)) begin
                $display("CHECK FAILED at %0t: game_won expected %b got %b",
                         $time, exp_outcome == OUT_WON, game_won);
                errs++;
            end
            if (game_lost !== (exp_outcome == OUT_LOST)) begin
                $display("CHECK FAILED at %0t: game_lost expected %b got %b",
                         $time, exp_outcome == OUT_LOST, game_lost);
                errs++;
            end
            if (game_timeout !== (exp_outcome == OUT_TIMEOUT)) begin
                $display("CHECK FAILED at %0t: game_timeout expected %b got %b",
                         $time, exp_outcome == OUT_TIMEOUT, game_timeout);
                errs++;
            end
            if (round !== exp_round) begin
                $display("CHECK FAILED at %0t: round expected %0d got %0d",
                         $time, exp_round, round);
                errs++;
            end
            if (play !== exp_play) begin
                $display("CHECK FAILED at %0t: play expected %b got %b", $time, exp_play, play);
                errs++;
            end
            tests_run++;
            if (errs == 0) begin
                $display("Test %s: ok", test_name);
            end else begin
                tests_failed++;
                $display("Test %s: %0d errors", test_name, errs);
            end
            check_req = 1'b0;
        end
    end

    // Stimulus
    initial begin
        int k;
        int bad_round;
        seed = 32'h5ca;
        arst_n = 1'b0;
        start = 1'b0;
        level = 1'b0;
        switches = '0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        exp_outcome = OUT_NONE;
        exp_round = '0;
        exp_play = '0;
        finish_test("reset_values");

        correct_game(1'b0, "win_level_low");
        correct_game(1'b1, "win_level_high");

        // Wrong pattern at a random round of a short game
        bad_round = $unsigned($random(seed)) % 8;
        game_level = 1'b0;
        n_plays = bad_round + 1;
        for (k = 0; k < n_plays; k++) begin
            pats[k] = seq_rom_contents[k];
            gaps[k] = random_gap();
        end
        pats[bad_round] = wrong_pattern(seq_rom_contents[bad_round]);
        play_game("lose_random_round");

        // Third press arrives far too late
        game_level = 1'b0;
        n_plays = 3;
        for (k = 0; k < n_plays; k++) begin
            pats[k] = seq_rom_contents[k];
            gaps[k] = random_gap();
        end
        gaps[2] = LONG_GAP;
        play_game("timeout");
        correct_game(1'b0, "win_after_timeout");

        // Press in the won state leaves every output unchanged
        press(4'b1010, 0);
        finish_test("press_in_outcome");

        @(posedge clock);
        $display("Tests run: %0d, tests failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== memory_game.f ====
verilog/memory_game_pkg.sv
verilog/play_capture.sv
verilog/sequence_memory.sv
verilog/play_timer.sv
verilog/game_control.sv
verilog/memory_game_top.sv
tb/memory_game_checker.sv
tb/memory_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --top-module memory_game_tb -f memory_game.f \
    -o memory_game_sim > "$LOG" 2>&1 &&
./obj_dir/memory_game_sim >> "$LOG" 2>&1 ||
echo "Simulation FAILED" >> "$LOG"
cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && exit 1 || exit 0
